/* fdc_pkg.sv */
/*
 * Shared definitions for the type II part of a WD279x-style FDC.
 * The command union covers read (100) and write (101) sector commands only.
 * CRC rule is CRC-16 CCITT, MSB first, polynomial 1021, preset after three A1 syncs.
 */
package fdc_pkg;

	// Type II command fields, most significant bit first
	typedef struct packed {
		logic [2:0] op;
		logic       multi;
		logic       side;
		logic       settle;
		logic       side_ctl;
		logic       dam_sel;
	} fdc_type2_t;

	// The host writes the raw byte and the sequencer reads the fields
	typedef union packed {
		logic [7:0] raw;
		fdc_type2_t f;
	} fdc_cmd_u;

	typedef enum logic [1:0] {
		REG_STATUS_CMD = 2'd0,
		REG_TRACK      = 2'd1,
		REG_SECTOR     = 2'd2,
		REG_DATA       = 2'd3
	} reg_addr_t;

	// Status bit positions for type II commands
	localparam int ST_NOT_READY   = 7;
	localparam int ST_WRITE_PROT  = 6;
	localparam int ST_RECORD_TYPE = 5;
	localparam int ST_RNF         = 4;
	localparam int ST_CRC_ERR     = 3;
	localparam int ST_LOST_DATA   = 2;
	localparam int ST_DRQ         = 1;
	localparam int ST_BUSY        = 0;

	// Byte positions inside the six-byte ID field
	localparam int ID_TRACK  = 0;
	localparam int ID_SIDE   = 1;
	localparam int ID_SECTOR = 2;
	localparam int ID_LENGTH = 3;

	localparam logic [7:0]  MARK_IDAM     = 8'hFE;
	localparam logic [7:0]  MARK_DAM      = 8'hFB;
	localparam logic [7:0]  MARK_DDAM     = 8'hF8;
	localparam logic [15:0] CRC_PRESET    = 16'hCDB4;
	localparam logic [7:0]  CMD_FORCE_INT = 8'hD0;

	// One byte through the CRC register, bit 7 first
	function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		c = crc;
		for (int i = 7; i >= 0; i--) begin
			if (c[15] ^ data[i])
				c = {c[14:0], 1'b0} ^ 16'h1021;
			else
				c = {c[14:0], 1'b0};
		end
		return c;
	endfunction

endpackage

/* fdc_disk_if.sv */
/*
 * Decoded disk events, all driven by the mark decoder.
 * idam_data holds the last captured ID field and is only meaningful
 * while idam_valid is high. data_rx is a one-cycle strobe per byte.
 */
`timescale 1ns/10ps

interface fdc_disk_if;

	logic [7:0]      rx_byte;
	logic            data_rx;
	logic            idam_valid;
	// Byte 0 is the track number, byte 5 the second ID CRC byte
	logic [5:0][7:0] idam_data;
	logic            dam_valid;
	logic            dam_deleted;
	logic            dam_crc_valid;

	modport decoder (
		output rx_byte, data_rx, idam_valid, idam_data,
		output dam_valid, dam_deleted, dam_crc_valid
	);

	modport seq (input idam_valid, idam_data, dam_valid, dam_deleted, dam_crc_valid, data_rx);

	modport regs (input rx_byte, data_rx);

endinterface

/* fdc_cmd_if.sv */
/*
 * Register file to sequencer traffic.
 * command_start, interrupt and intrq_ack are single-cycle strobes decoded
 * straight from the host access. status is combinational in the sequencer.
 */
`timescale 1ns/10ps

interface fdc_cmd_if import fdc_pkg::*; ();

	// Driven by the register file
	fdc_cmd_u   command;
	logic [7:0] track;
	logic [7:0] sector;
	logic       command_start;
	logic       interrupt;
	logic       intrq_ack;
	logic       drq;

	// Driven by the sequencer
	logic [7:0] status;
	logic       enable_write_reg_data;
	logic [7:0] sector_out;
	logic       sector_write;
	logic       intrq;

	modport regs (
		output command, track, sector, command_start, interrupt, intrq_ack, drq,
		input  status, enable_write_reg_data, sector_out, sector_write
	);

	modport seq (
		input  command, track, sector, command_start, interrupt, intrq_ack, drq,
		output status, enable_write_reg_data, sector_out, sector_write, intrq
	);

endinterface

/* fdc_mark_decoder.sv */
/*
 * Address mark decoder behind an external data separator.
 * disk_mark qualifies a byte as an address mark, after the A1 syncs.
 * A data mark only counts inside the gap window that follows an ID field.
 * The ID CRC is captured but not checked.
 */
`timescale 1ns/10ps

module fdc_mark_decoder import fdc_pkg::*; #(
	parameter int id_gap_bytes = 20
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] disk_byte,
	input  logic       disk_byte_valid,
	input  logic       disk_mark,
	fdc_disk_if.decoder disk
);

	localparam int GAP_W = $clog2(id_gap_bytes + 1);
	localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(id_gap_bytes - 1);

	typedef enum logic [2:0] {
		DS_HUNT,
		DS_ID,
		DS_GAP,
		DS_DATA,
		DS_CRC
	} dec_state_t;

	dec_state_t       state;
	logic [9:0]       byte_cnt;
	logic [GAP_W-1:0] gap_cnt;
	logic [15:0]      crc;
	logic [15:0]      crc_next;
	logic [10:0]      data_len;

	// Sector size is 128 bytes shifted left by the ID length code
	assign data_len = 11'd128 << disk.idam_data[ID_LENGTH][1:0];

	// The register restarts from the sync preset on every mark
	assign crc_next = crc16_step(disk_mark ? CRC_PRESET : crc, disk_byte);

	always_ff @(posedge clk) begin
		disk.data_rx <= 1'b0;
		if (reset) begin
			state              <= DS_HUNT;
			disk.idam_valid    <= 1'b0;
			disk.dam_valid     <= 1'b0;
			disk.dam_deleted   <= 1'b0;
			disk.dam_crc_valid <= 1'b0;
		end else begin
			// Data field is over, drop dam_valid one cycle after the last data strobe
			if (state == DS_CRC)
				disk.dam_valid <= 1'b0;

			if (disk_byte_valid && disk_mark) begin
				crc                <= crc_next;
				byte_cnt           <= '0;
				disk.dam_valid     <= 1'b0;
				disk.dam_crc_valid <= 1'b0;
				if (disk_byte == MARK_IDAM) begin
					state           <= DS_ID;
					disk.idam_valid <= 1'b0;
				end else if ((disk_byte == MARK_DAM || disk_byte == MARK_DDAM)
						&& state == DS_GAP) begin
					// Data mark inside the window of the ID just read
					state            <= DS_DATA;
					disk.dam_valid   <= 1'b1;
					disk.dam_deleted <= disk_byte == MARK_DDAM;
				end else begin
					state           <= DS_HUNT;
					disk.idam_valid <= 1'b0;
				end
			end else if (disk_byte_valid && state != DS_HUNT) begin
				crc          <= crc_next;
				disk.rx_byte <= disk_byte;
				disk.data_rx <= 1'b1;
				case (state)
					DS_ID: begin
						disk.idam_data[byte_cnt[2:0]] <= disk_byte;
						if (byte_cnt == 10'd5) begin
							state           <= DS_GAP;
							disk.idam_valid <= 1'b1;
							gap_cnt         <= '0;
						end else begin
							byte_cnt <= byte_cnt + 10'd1;
						end
					end
					DS_GAP: begin
						// No data mark in time, the ID is no longer usable
						if (gap_cnt == GAP_LAST) begin
							state           <= DS_HUNT;
							disk.idam_valid <= 1'b0;
						end else begin
							gap_cnt <= gap_cnt + 1'b1;
						end
					end
					DS_DATA: begin
						if ({1'b0, byte_cnt} == data_len - 11'd1) begin
							state    <= DS_CRC;
							byte_cnt <= '0;
						end else begin
							byte_cnt <= byte_cnt + 10'd1;
						end
					end
					DS_CRC: begin
						if (byte_cnt[0]) begin
							// A good field leaves the register at zero after both CRC bytes
							state              <= DS_HUNT;
							disk.idam_valid    <= 1'b0;
							disk.dam_crc_valid <= crc_next == 16'h0000;
						end else begin
							byte_cnt <= 10'd1;
						end
					end
					default: state <= DS_HUNT;
				endcase
			end
		end
	end

	// A data field can never open on the same edge that completes an ID capture
	a_dam_not_with_idam: assert property (@(posedge clk) disable iff (reset)
		$rose(disk.idam_valid) |-> !$rose(disk.dam_valid));

endmodule

/* fdc_type2_seq.sv */
/*
 * Type II (read/write sector) command sequencer.
 * side_output 1 drives sso from the command, 0 compares the ID side byte.
 * Write commands stop once the data mark is found, no data is written.
 * Lost data is never flagged. Force-interrupt only aborts to idle.
 */
`timescale 1ns/10ps

module fdc_type2_seq import fdc_pkg::*; #(
	parameter bit side_output = 1'b1,
	parameter int clks_per_ms = 8000
) (
	input  logic clk,
	input  logic reset,
	input  logic index_n,
	input  logic ready_n,
	input  logic wprot_n,
	output logic hld,
	output logic sso,
	fdc_disk_if.seq disk,
	fdc_cmd_if.seq  cmd
);

	localparam int MS_W = $clog2(clks_per_ms + 1);
	localparam logic [MS_W-1:0] MS_LAST = MS_W'(clks_per_ms - 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREPARE,
		ST_SETTLE,
		ST_SEARCH,
		ST_WAIT_DAM,
		ST_READ,
		ST_CRC_CHECK,
		ST_CMD_END
	} seq_state_t;

	seq_state_t      state;
	logic [MS_W-1:0] ms_count;
	logic            ms_tick;
	logic [3:0]      wait_count;
	logic [2:0]      index_count;
	logic            index_prev;
	logic [1:0]      crc_count;
	logic            type2;
	logic            is_write;
	logic            id_match;
	logic            wp_flag;
	logic            rtype_flag;
	logic            rnf_flag;
	logic            crc_flag;

	assign type2    = cmd.command.f.op[2:1] == 2'b10;
	assign is_write = cmd.command.f.op[0];

	// Side compare applies only to the 2791/93 variant and only when enabled
	assign id_match = disk.idam_data[ID_TRACK] == cmd.track
		&& disk.idam_data[ID_SECTOR] == cmd.sector
		&& (side_output || !cmd.command.f.side_ctl
			|| disk.idam_data[ID_SIDE][0] == cmd.command.f.side);

	// Free running 1 ms prescaler for the settle delay
	always_ff @(posedge clk) begin
		if (reset) begin
			ms_count <= '0;
			ms_tick  <= 1'b0;
		end else begin
			ms_tick  <= ms_count == MS_LAST;
			ms_count <= (ms_count == MS_LAST) ? '0 : ms_count + 1'b1;
		end
	end

	// Status reads as zero unless the last command was type II
	always_comb begin
		cmd.status = 8'h00;
		if (type2) begin
			cmd.status[ST_NOT_READY]   = ready_n;
			cmd.status[ST_WRITE_PROT]  = wp_flag;
			cmd.status[ST_RECORD_TYPE] = rtype_flag;
			cmd.status[ST_RNF]         = rnf_flag;
			cmd.status[ST_CRC_ERR]     = crc_flag;
			cmd.status[ST_LOST_DATA]   = 1'b0;
			cmd.status[ST_DRQ]         = cmd.drq;
			cmd.status[ST_BUSY]        = state != ST_IDLE;
		end
	end

	// Only bytes inside the data field go to the data register, CRC bytes do not
	assign cmd.enable_write_reg_data = state == ST_READ && disk.dam_valid;

	always_ff @(posedge clk) begin
		cmd.sector_write <= 1'b0;
		if (reset || cmd.interrupt) begin
			state       <= ST_IDLE;
			hld         <= 1'b0;
			sso         <= 1'b0;
			cmd.intrq   <= 1'b0;
			wp_flag     <= 1'b0;
			rtype_flag  <= 1'b0;
			rnf_flag    <= 1'b0;
			crc_flag    <= 1'b0;
			index_prev  <= 1'b1;
			index_count <= '0;
			wait_count  <= '0;
			crc_count   <= '0;
		end else begin
			// Count falling edges of the index pulse, saturating
			index_prev <= index_n;
			if (index_prev && !index_n && index_count != 3'd7)
				index_count <= index_count + 3'd1;
			if (cmd.intrq_ack)
				cmd.intrq <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (cmd.command_start) begin
						cmd.intrq  <= 1'b0;
						wp_flag    <= 1'b0;
						rtype_flag <= 1'b0;
						rnf_flag   <= 1'b0;
						crc_flag   <= 1'b0;
						state      <= ST_PREPARE;
					end
				end
				ST_PREPARE: begin
					// The command register holds the new byte from here on
					if (!type2) begin
						state <= ST_IDLE;
					end else if (ready_n) begin
						cmd.intrq <= 1'b1;
						state     <= ST_IDLE;
					end else begin
						if (side_output)
							sso <= cmd.command.f.side_ctl;
						hld        <= 1'b1;
						wait_count <= cmd.command.f.settle ? 4'd15 : 4'd0;
						state      <= ST_SETTLE;
					end
				end
				ST_SETTLE: begin
					if (wait_count != 4'd0) begin
						if (ms_tick)
							wait_count <= wait_count - 4'd1;
					end else begin
						index_count <= '0;
						if (is_write && !wprot_n) begin
							wp_flag   <= 1'b1;
							cmd.intrq <= 1'b1;
							state     <= ST_IDLE;
						end else begin
							state <= ST_SEARCH;
						end
					end
				end
				ST_SEARCH: begin
					if (index_count > 3'd4) begin
						rnf_flag  <= 1'b1;
						cmd.intrq <= 1'b1;
						state     <= ST_IDLE;
					end else if (disk.idam_valid && !disk.dam_valid && id_match) begin
						state <= ST_WAIT_DAM;
					end
				end
				ST_WAIT_DAM: begin
					if (disk.dam_valid) begin
						rtype_flag <= disk.dam_deleted;
						if (is_write) begin
							cmd.intrq <= 1'b1;
							state     <= ST_IDLE;
						end else begin
							state <= ST_READ;
						end
					end else if (!disk.idam_valid) begin
						// Gap window ran out, look for the next ID
						state <= ST_SEARCH;
					end
				end
				ST_READ: begin
					// The first CRC byte may already be strobed here
					if (!disk.dam_valid) begin
						crc_count <= disk.data_rx ? 2'd1 : 2'd2;
						state     <= ST_CRC_CHECK;
					end
				end
				ST_CRC_CHECK: begin
					if (crc_count != 2'd0) begin
						if (disk.data_rx)
							crc_count <= crc_count - 2'd1;
					end else if (!disk.dam_crc_valid) begin
						crc_flag  <= 1'b1;
						cmd.intrq <= 1'b1;
						state     <= ST_IDLE;
					end else if (cmd.command.f.multi) begin
						cmd.sector_out   <= cmd.sector + 8'd1;
						cmd.sector_write <= 1'b1;
						state            <= ST_SETTLE;
					end else begin
						state <= ST_CMD_END;
					end
				end
				ST_CMD_END: begin
					// Completion waits until the host has taken the last byte
					if (!cmd.drq) begin
						cmd.intrq <= 1'b1;
						state     <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_intrq_from_active: assert property (@(posedge clk) disable iff (reset)
		$rose(cmd.intrq) |-> $past(state) != ST_IDLE);

	a_sector_write_after_crc: assert property (@(posedge clk) disable iff (reset)
		cmd.sector_write |-> $past(state) == ST_CRC_CHECK);

endmodule

/* fdc_regs.sv */
/*
 * Host register file. One access per cycle while cs is high.
 * rdata is combinational. A new command is ignored while busy,
 * except force-interrupt. There is no back-pressure on the data register.
 */
`timescale 1ns/10ps

module fdc_regs import fdc_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cs,
	input  logic       we,
	input  reg_addr_t  addr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       drq,
	fdc_disk_if.regs   disk,
	fdc_cmd_if.regs    cmd
);

	logic       host_wr;
	logic       host_rd;
	logic       cmd_wr;
	logic       busy;
	logic       data_load;
	logic [7:0] data_reg;

	assign host_wr   = cs && we;
	assign host_rd   = cs && !we;
	assign cmd_wr    = host_wr && addr == REG_STATUS_CMD;
	assign busy      = cmd.status[ST_BUSY];
	assign data_load = disk.data_rx && cmd.enable_write_reg_data;

	// Strobes come straight from the host access cycle
	assign cmd.command_start = cmd_wr && wdata != CMD_FORCE_INT && !busy;
	assign cmd.interrupt     = cmd_wr && wdata == CMD_FORCE_INT;
	assign cmd.intrq_ack     = host_rd && addr == REG_STATUS_CMD;

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd.command <= '0;
			cmd.track   <= '0;
			cmd.sector  <= '0;
			drq         <= 1'b0;
		end else begin
			if (cmd.command_start || cmd.interrupt)
				cmd.command.raw <= wdata;
			if (host_wr && addr == REG_TRACK)
				cmd.track <= wdata;
			// Multi-sector advance takes priority over a host write
			if (cmd.sector_write)
				cmd.sector <= cmd.sector_out;
			else if (host_wr && addr == REG_SECTOR)
				cmd.sector <= wdata;
			if (cmd.interrupt)
				drq <= 1'b0;
			else if (data_load)
				drq <= 1'b1;
			else if (host_rd && addr == REG_DATA)
				drq <= 1'b0;
		end
	end

	// A disk byte overwrites whatever the host left in the data register
	always_ff @(posedge clk) begin
		if (data_load)
			data_reg <= disk.rx_byte;
		else if (host_wr && addr == REG_DATA)
			data_reg <= wdata;
	end

	assign cmd.drq = drq;

	always_comb begin
		case (addr)
			REG_STATUS_CMD: rdata = cmd.status;
			REG_TRACK:      rdata = cmd.track;
			REG_SECTOR:     rdata = cmd.sector;
			default:        rdata = data_reg;
		endcase
	end

endmodule

/* fdc_top.sv */
/*
 * Type II part of a WD279x-style FDC.
 * Expects decoded bytes from an external data separator, one strobe per byte.
 * side_output selects 2795/97 (1) or 2791/93 (0) behaviour.
 */
`timescale 1ns/10ps

module fdc_top import fdc_pkg::*; #(
	parameter bit side_output  = 1'b1,
	parameter int clks_per_ms  = 8000,
	parameter int id_gap_bytes = 20
) (
	input  logic       clk,
	input  logic       reset,
	// Host side
	input  logic       cs,
	input  logic       we,
	input  reg_addr_t  addr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       intrq,
	output logic       drq,
	// Drive side
	input  logic       index_n,
	input  logic       ready_n,
	input  logic       wprot_n,
	input  logic [7:0] disk_byte,
	input  logic       disk_byte_valid,
	input  logic       disk_mark,
	output logic       hld,
	output logic       sso
);

	fdc_disk_if disk_bus ();
	fdc_cmd_if  cmd_bus ();

	fdc_mark_decoder #(
		.id_gap_bytes(id_gap_bytes)
	) u_decoder (
		.clk, .reset, .disk_byte, .disk_byte_valid, .disk_mark,
		.disk(disk_bus.decoder)
	);

	fdc_type2_seq #(
		.side_output(side_output),
		.clks_per_ms(clks_per_ms)
	) u_seq (
		.clk, .reset, .index_n, .ready_n, .wprot_n, .hld, .sso,
		.disk(disk_bus.seq),
		.cmd(cmd_bus.seq)
	);

	fdc_regs u_regs (
		.clk, .reset, .cs, .we, .addr, .wdata, .rdata, .drq,
		.disk(disk_bus.regs),
		.cmd(cmd_bus.regs)
	);

	// Interrupt request is owned by the sequencer
	assign intrq = cmd_bus.intrq;

endmodule

/* fdc_tb.sv */
/*
 * Directed testbench for the type II FDC top level (2791/93 variant).
 * Disk bytes arrive one every BYTE_CLKS cycles so the host can drain each
 * data byte before the next one. Sectors are always 128 bytes (length code 0).
 * Random sector data comes from $urandom with a fixed seed.
 */
`timescale 1ns/10ps

module fdc_tb import fdc_pkg::*; ();

	localparam int CLK_NS    = 4;
	localparam int BYTE_CLKS = 6;
	localparam int IMG_MAX   = 512;
	// Four quiet cycles and a two-cycle index pulse start every revolution
	localparam int REV_CLKS    = IMG_MAX * BYTE_CLKS + 6;
	localparam int N_TESTS     = 6;
	localparam int WATCHDOG_NS = N_TESTS * 6 * REV_CLKS * CLK_NS;

	logic       clk;
	logic       reset;
	logic       cs;
	logic       we;
	reg_addr_t  addr;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic       intrq;
	logic       drq;
	logic       index_n;
	logic       ready_n;
	logic       wprot_n;
	logic [7:0] disk_byte;
	logic       disk_byte_valid;
	logic       disk_mark;
	logic       hld;
	logic       sso;

	// Track image and the data bytes the host should read back
	logic [7:0]  img_byte[$];
	bit          img_mark[$];
	logic [7:0]  exp_q[$];
	bit          stream_stop;
	int          index_pulses;
	int unsigned seed_value;

	fdc_top #(
		.side_output(1'b0),
		.clks_per_ms(4),
		.id_gap_bytes(20)
	) uut (
		.clk, .reset, .cs, .we, .addr, .wdata, .rdata, .intrq, .drq,
		.index_n, .ready_n, .wprot_n, .disk_byte, .disk_byte_valid, .disk_mark,
		.hld, .sso
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_status(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("FAILED status: got 0x%h, expected 0x%h", got, exp));
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// CCITT CRC-16, polynomial 1021, most significant bit first
	function automatic logic [15:0] crc_update(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] r;
		logic        fb;
		r = crc;
		for (int i = 7; i >= 0; i--) begin
			fb = r[15] ^ b[i];
			r  = r << 1;
			if (fb)
				r = r ^ 16'h1021;
		end
		return r;
	endfunction

	// Expected type II status byte, bit positions as in the datasheet
	function automatic logic [7:0] make_status(input bit not_ready, wp, rtype, rnf, crc_err,
			drq_set, busy);
		logic [7:0] s;
		s                 = 8'h00;
		s[ST_NOT_READY]   = not_ready;
		s[ST_WRITE_PROT]  = wp;
		s[ST_RECORD_TYPE] = rtype;
		s[ST_RNF]         = rnf;
		s[ST_CRC_ERR]     = crc_err;
		s[ST_DRQ]         = drq_set;
		s[ST_BUSY]        = busy;
		return s;
	endfunction

	function automatic logic [7:0] type2_cmd(input bit write, multi, side, settle, side_ctl);
		fdc_cmd_u c;
		c.raw        = 8'h00;
		c.f.op       = write ? 3'b101 : 3'b100;
		c.f.multi    = multi;
		c.f.side     = side;
		c.f.settle   = settle;
		c.f.side_ctl = side_ctl;
		return c.raw;
	endfunction

	function automatic void put_byte(input logic [7:0] b, input bit m);
		img_byte.push_back(b);
		img_mark.push_back(m);
	endfunction

	function automatic void add_gap(input int n);
		for (int i = 0; i < n; i++)
			put_byte(8'h4E, 1'b0);
	endfunction

	task automatic new_image();
		img_byte.delete();
		img_mark.delete();
		exp_q.delete();
		stream_stop = 1'b0;
	endtask

	// One sector: gap, ID field with its CRC, gap, data field with its CRC, gap
	task automatic add_sector(input logic [7:0] trk, side, sec, input bit deleted, corrupt, keep);
		logic [7:0]  id[4];
		logic [7:0]  d;
		logic [15:0] crc;
		logic [31:0] rnd;
		id[ID_TRACK]  = trk;
		id[ID_SIDE]   = side;
		id[ID_SECTOR] = sec;
		id[ID_LENGTH] = 8'h00;
		add_gap(8);
		put_byte(MARK_IDAM, 1'b1);
		crc = crc_update(CRC_PRESET, MARK_IDAM);
		for (int i = 0; i < 4; i++) begin
			put_byte(id[i], 1'b0);
			crc = crc_update(crc, id[i]);
		end
		put_byte(crc[15:8], 1'b0);
		put_byte(crc[7:0], 1'b0);
		add_gap(10);
		d = deleted ? MARK_DDAM : MARK_DAM;
		put_byte(d, 1'b1);
		crc = crc_update(CRC_PRESET, d);
		for (int i = 0; i < 128; i++) begin
			rnd = $urandom;
			d   = rnd[7:0];
			put_byte(d, 1'b0);
			crc = crc_update(crc, d);
			if (keep)
				exp_q.push_back(d);
		end
		// A single flipped bit is enough to break the check
		if (corrupt)
			crc = crc ^ 16'h0001;
		put_byte(crc[15:8], 1'b0);
		put_byte(crc[7:0], 1'b0);
		add_gap(8);
		if (img_byte.size() > IMG_MAX)
			stop_with_error("Track image is longer than the watchdog budget allows");
	endtask

	// Revolutions only stop at the index, so the decoder always ends in a gap
	task automatic stream_image(input int max_revs);
		index_pulses = 0;
		for (int r = 0; r < max_revs && !stream_stop; r++) begin
			repeat (4) @(posedge clk);
			index_n <= 1'b0;
			index_pulses++;
			repeat (2) @(posedge clk);
			index_n <= 1'b1;
			foreach (img_byte[i]) begin
				@(posedge clk);
				disk_byte       <= img_byte[i];
				disk_mark       <= img_mark[i];
				disk_byte_valid <= 1'b1;
				@(posedge clk);
				disk_byte_valid <= 1'b0;
				disk_mark       <= 1'b0;
				repeat (BYTE_CLKS - 2) @(posedge clk);
			end
		end
	endtask

	task automatic host_write(input reg_addr_t a, input logic [7:0] d);
		@(posedge clk);
		cs    <= 1'b1;
		we    <= 1'b1;
		addr  <= a;
		wdata <= d;
		@(posedge clk);
		cs <= 1'b0;
		we <= 1'b0;
	endtask

	// rdata is combinational, so it is sampled mid-cycle
	task automatic host_read(input reg_addr_t a, output logic [7:0] d);
		@(posedge clk);
		cs   <= 1'b1;
		we   <= 1'b0;
		addr <= a;
		@(negedge clk);
		d = rdata;
		@(posedge clk);
		cs <= 1'b0;
	endtask

	task automatic wait_drq(input int max_cycles);
		int n;
		n = 0;
		@(negedge clk);
		while (drq !== 1'b1) begin
			if (n == max_cycles) begin
				stop_with_error("drq did not rise while a data byte was expected");
			end else begin
				n++;
				@(negedge clk);
			end
		end
	endtask

	task automatic wait_intrq(input int max_cycles);
		int n;
		n = 0;
		@(negedge clk);
		while (intrq !== 1'b1) begin
			if (n == max_cycles) begin
				stop_with_error("intrq did not rise before the command timeout");
			end else begin
				n++;
				@(negedge clk);
			end
		end
	endtask

	task automatic wait_sector(input logic [7:0] exp);
		logic [7:0] v;
		int         n;
		n = 0;
		host_read(REG_SECTOR, v);
		while (v !== exp) begin
			if (n == 100) begin
				stop_with_error("Sector register did not advance after a good data CRC");
			end else begin
				n++;
				host_read(REG_SECTOR, v);
			end
		end
	endtask

	task automatic read_bytes(input int count);
		logic [7:0] b;
		for (int i = 0; i < count; i++) begin
			wait_drq(2 * REV_CLKS);
			host_read(REG_DATA, b);
			check_byte("data", b, exp_q.pop_front());
		end
	endtask

	// Busy must show in status on the cycle after the command write
	task automatic start_command(input logic [7:0] command);
		host_write(REG_STATUS_CMD, command);
		@(negedge clk);
		check_flag("busy", rdata[ST_BUSY], 1'b1);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic check_idle_outputs();
		logic [7:0] s;
		@(negedge clk);
		check_flag("intrq", intrq, 1'b0);
		check_flag("drq", drq, 1'b0);
		check_flag("hld", hld, 1'b0);
		check_flag("sso", sso, 1'b0);
		host_read(REG_STATUS_CMD, s);
		check_status(s, 8'h00);
	endtask

	// Wrong track, then wrong sector, then the wanted ID
	task automatic test_single_read();
		logic [7:0] s;
		new_image();
		add_sector(8'd6, 8'd0, 8'd3, 1'b0, 1'b0, 1'b0);
		add_sector(8'd5, 8'd0, 8'd7, 1'b0, 1'b0, 1'b0);
		add_sector(8'd5, 8'd0, 8'd3, 1'b0, 1'b0, 1'b1);
		host_write(REG_TRACK, 8'd5);
		host_write(REG_SECTOR, 8'd3);
		start_command(type2_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		fork
			stream_image(2);
			begin
				read_bytes(128);
				wait_intrq(REV_CLKS);
				stream_stop = 1'b1;
			end
		join
		check_flag("drq", drq, 1'b0);
		host_read(REG_STATUS_CMD, s);
		check_status(s, make_status(0, 0, 0, 0, 0, 0, 0));
	endtask

	// Sector 4 carries a deleted mark, the run ends when sector 5 is not found
	task automatic test_multi_read();
		logic [7:0] s;
		new_image();
		add_sector(8'd5, 8'd0, 8'd3, 1'b0, 1'b0, 1'b1);
		add_sector(8'd5, 8'd0, 8'd4, 1'b1, 1'b0, 1'b1);
		host_write(REG_SECTOR, 8'd3);
		start_command(type2_cmd(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		fork
			stream_image(8);
			begin
				read_bytes(256);
				wait_sector(8'd5);
				host_read(REG_STATUS_CMD, s);
				check_status(s, make_status(0, 0, 1, 0, 0, 0, 1));
				wait_intrq(7 * REV_CLKS);
				stream_stop = 1'b1;
			end
		join
		host_read(REG_STATUS_CMD, s);
		check_status(s, make_status(0, 0, 1, 1, 0, 0, 0));
	endtask

	// Also runs with the 15 ms head settle delay
	task automatic test_crc_error();
		logic [7:0] s;
		new_image();
		add_sector(8'd5, 8'd0, 8'd3, 1'b0, 1'b1, 1'b1);
		host_write(REG_SECTOR, 8'd3);
		start_command(type2_cmd(1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
		fork
			stream_image(2);
			begin
				read_bytes(128);
				wait_intrq(REV_CLKS);
				stream_stop = 1'b1;
			end
		join
		host_read(REG_STATUS_CMD, s);
		check_status(s, make_status(0, 0, 0, 0, 1, 0, 0));
	endtask

	task automatic run_not_found(input logic [7:0] command);
		logic [7:0] s;
		start_command(command);
		fork
			stream_image(7);
			begin
				wait_intrq(7 * REV_CLKS);
				if (index_pulses != 5)
					stop_with_error("Record not found was not raised on the fifth index pulse");
				stream_stop = 1'b1;
			end
		join
		host_read(REG_STATUS_CMD, s);
		check_status(s, make_status(0, 0, 0, 1, 0, 0, 0));
	endtask

	task automatic test_not_found();
		new_image();
		add_sector(8'd5, 8'd0, 8'd1, 1'b0, 1'b0, 1'b0);
		add_sector(8'd5, 8'd0, 8'd2, 1'b0, 1'b0, 1'b0);
		host_write(REG_SECTOR, 8'd9);
		run_not_found(type2_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		// Right track and sector, but the ID says side 1 and side compare is on
		new_image();
		add_sector(8'd5, 8'd1, 8'd3, 1'b0, 1'b0, 1'b0);
		host_write(REG_SECTOR, 8'd3);
		run_not_found(type2_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
	endtask

	task automatic test_drive_checks();
		logic [7:0] s;
		@(posedge clk);
		ready_n <= 1'b1;
		start_command(type2_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		check_flag("intrq", intrq, 1'b0);
		@(negedge clk);
		check_flag("intrq", intrq, 1'b1);
		host_read(REG_STATUS_CMD, s);
		check_status(s, make_status(1, 0, 0, 0, 0, 0, 0));
		@(posedge clk);
		ready_n <= 1'b0;
		wprot_n <= 1'b0;
		start_command(type2_cmd(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
		wait_intrq(50);
		host_read(REG_STATUS_CMD, s);
		check_status(s, make_status(0, 1, 0, 0, 0, 0, 0));
		@(posedge clk);
		wprot_n <= 1'b1;
	endtask

	// Abort a search for a sector that is not on the track
	task automatic test_force_interrupt();
		new_image();
		add_sector(8'd5, 8'd0, 8'd1, 1'b0, 1'b0, 1'b0);
		host_write(REG_SECTOR, 8'd9);
		start_command(type2_cmd(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		fork
			stream_image(3);
			begin
				repeat (300) @(posedge clk);
				@(negedge clk);
				check_flag("hld", hld, 1'b1);
				check_flag("busy", rdata[ST_BUSY], 1'b1);
				host_write(REG_STATUS_CMD, CMD_FORCE_INT);
				@(negedge clk);
				check_status(rdata, 8'h00);
				check_flag("hld", hld, 1'b0);
				check_flag("intrq", intrq, 1'b0);
				check_flag("drq", drq, 1'b0);
				stream_stop = 1'b1;
			end
		join
		apply_reset();
		check_idle_outputs();
	endtask

	initial begin
		cs              = 1'b0;
		we              = 1'b0;
		addr            = REG_STATUS_CMD;
		wdata           = 8'h00;
		index_n         = 1'b1;
		ready_n         = 1'b0;
		wprot_n         = 1'b1;
		disk_byte       = 8'h00;
		disk_byte_valid = 1'b0;
		disk_mark       = 1'b0;
		reset           = 1'b1;
		stream_stop     = 1'b0;
		index_pulses    = 0;
		seed_value      = $urandom(32);
		apply_reset();
		check_idle_outputs();
		test_single_read();
		test_multi_read();
		test_crc_error();
		test_not_found();
		test_drive_checks();
		test_force_interrupt();
		$display("NO ERRORS");
		$finish;
	end

	// Budget of six full-length revolutions for every test
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("ERRORS FOUND");
		$fatal(1);
	end

endmodule

/* files.f */
fdc_pkg.sv
fdc_disk_if.sv
fdc_cmd_if.sv
fdc_mark_decoder.sv
fdc_type2_seq.sv
fdc_regs.sv
fdc_top.sv
fdc_tb.sv

/* Bender.yml */
package:
  name: fdc_type2

sources:
  - fdc_pkg.sv
  - fdc_disk_if.sv
  - fdc_cmd_if.sv
  - fdc_mark_decoder.sv
  - fdc_type2_seq.sv
  - fdc_regs.sv
  - fdc_top.sv
  - target: simulation
    files:
      - fdc_tb.sv
